//--- rv32_exec_core.f
+incdir+include
source/rv32_exec_pkg.sv
source/fu_issue_if.sv
source/wb_port_if.sv
source/control_unit.sv
source/reg_file.sv
source/arith_unit.sv
source/mul_unit.sv
source/div_unit.sv
source/wb_arbiter.sv
source/rv32_exec_core.sv
tests/tb_rv32_exec_core.sv

//--- Makefile
TOP  := tb_rv32_exec_core
SRCS := $(shell grep -v '^+' rv32_exec_core.f) include/rv32_exec_consts.svh

.PHONY: run clean

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

obj_dir/V$(TOP): rv32_exec_core.f $(SRCS)
	verilator --binary --assert -j 0 --top-module $(TOP) -f rv32_exec_core.f

clean:
	rm -rf obj_dir

//--- tests/tb_rv32_exec_core.sv
// testbench for the rv32 decode, issue and execute slice
// directed tests checked against a sequential ISA model of the registers
`timescale 1ns/1ps
`default_nettype none

`include "rv32_exec_consts.svh"

module tb_rv32_exec_core;

  localparam int ACCEPT_TIMEOUT = 100;
  localparam int DRAIN_TIMEOUT  = 200;

  logic CLK;
  logic reset_i;
  logic [`XLEN-1:0] instr_i;
  logic instr_valid_i;
  logic accept_o, illegal_o, wb_valid_o;
  logic [4:0] wb_rd_o;
  logic [`XLEN-1:0] wb_data_o;

  // program-order model of the registers
  // the scoreboard allows one write in flight per register
  logic [31:0] ref_regs [`NUM_REGS];
  logic [31:0] exp_val [`NUM_REGS];
  logic exp_pend [`NUM_REGS];
  int write_order [`NUM_REGS];
  int outstanding, write_seq, errors, checks;

  rv32_exec_core dut (
    .CLK           (CLK),
    .reset_i       (reset_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .accept_o      (accept_o),
    .illegal_o     (illegal_o),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o)
  );

  always #5 CLK = ~CLK;

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [4:0] rand_reg(input int lo);
    return 5'(lo + ($urandom % (32 - lo)));
  endfunction

  function automatic bit is_legal(input logic [31:0] instr);
    case (instr[6:0])
      7'b0110011: return instr[31:25] == 7'h00 || instr[31:25] == 7'h01 ||
                         (instr[31:25] == 7'h20 &&
                          (instr[14:12] == 3'd0 || instr[14:12] == 3'd5));
      7'b0010011, 7'b0110111: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // M extension results with products taken over 64 bits
  function automatic logic [31:0] m_ext_result(input logic [2:0] f3, input logic [31:0] a,
                                               input logic [31:0] b);
    logic [63:0] xa, xb, prod;
    logic signed [31:0] sa, sb, sres;
    xa = (f3 == 3'd1 || f3 == 3'd2) ? {{32{a[31]}}, a} : {32'b0, a};
    xb = (f3 == 3'd1) ? {{32{b[31]}}, b} : {32'b0, b};
    prod = xa * xb;
    sa = a;
    sb = b;
    case (f3)
      3'd0: return prod[31:0];
      3'd1, 3'd2, 3'd3: return prod[63:32];
      3'd4: begin
        if (b == 0) return '1;
        if (a == 32'h8000_0000 && b == '1) return a;
        sres = sa / sb;
        return sres;
      end
      3'd5: return (b == 0) ? '1 : a / b;
      3'd6: begin
        if (b == 0) return a;
        if (a == 32'h8000_0000 && b == '1) return '0;
        sres = sa % sb;
        return sres;
      end
      default: return (b == 0) ? a : a % b;
    endcase
  endfunction

  function automatic logic [31:0] isa_result(input logic [31:0] instr, input logic [31:0] a,
                                             input logic [31:0] rs2_val);
    logic [31:0] b;
    logic [2:0] f3;
    logic is_reg;
    f3 = instr[14:12];
    is_reg = (instr[6:0] == 7'b0110011);
    b = is_reg ? rs2_val : {{20{instr[31]}}, instr[31:20]};
    if (instr[6:0] == 7'b0110111) return {instr[31:12], 12'h000};
    if (is_reg && instr[31:25] == 7'h01) return m_ext_result(f3, a, b);
    case (f3)
      3'd0: return (is_reg && instr[30]) ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (instr[30]) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic check_word(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // holds the instruction until accepted, then updates the model in program order
  task automatic issue_instr(input logic [31:0] instr);
    int waited;
    logic [4:0] rd;
    logic [31:0] res;
    waited = 0;
    rd = instr[11:7];
    instr_i = instr;
    instr_valid_i = 1'b1;
    @(negedge CLK);
    while (!accept_o && waited < ACCEPT_TIMEOUT) begin
      @(negedge CLK);
      waited++;
    end
    if (!accept_o) begin
      errors++;
      $display("timeout: instruction %h not accepted within %0d cycles", instr, ACCEPT_TIMEOUT);
    end else if (is_legal(instr) && rd != 5'd0) begin
      res = isa_result(instr, ref_regs[instr[19:15]], ref_regs[instr[24:20]]);
      ref_regs[rd] = res;
      exp_val[rd] = res;
      exp_pend[rd] = 1'b1;
      outstanding++;
    end
    @(posedge CLK);
    #1;
    instr_valid_i = 1'b0;
  endtask

  // LUI then ADDI with the upper part rounded for the sign of the low twelve bits
  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    logic [19:0] hi;
    hi = value[31:12] + 20'(value[11]);
    issue_instr({hi, rd, 7'b0110111});
    issue_instr(enc_i(value[11:0], rd, 3'd0, rd));
  endtask

  // each high cycle seen mid-cycle is one write at the next edge
  task automatic watch_writeback();
    forever begin
      @(negedge CLK);
      if (!reset_i && wb_valid_o) begin
        write_seq++;
        if (wb_rd_o == 5'd0 || !exp_pend[wb_rd_o]) begin
          errors++;
          $display("** Error at %0t: unexpected write of %h to x%0d", $time, wb_data_o, wb_rd_o);
        end else begin
          check_word(wb_data_o, exp_val[wb_rd_o], $sformatf("write to x%0d", wb_rd_o));
          exp_pend[wb_rd_o] = 1'b0;
          write_order[wb_rd_o] = write_seq;
          outstanding--;
        end
      end
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (outstanding != 0 && waited < DRAIN_TIMEOUT) begin
      @(posedge CLK);
      #1;
      waited++;
    end
    if (outstanding != 0) begin
      errors++;
      $display("timeout: %0d writebacks missing after %0d cycles", outstanding, DRAIN_TIMEOUT);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("%-14s %s, %0d errors", name, (errors == err_before) ? "ok" : "FAILED",
             errors - err_before);
  endtask

  task automatic reset_and_load();
    int i;
    // accept does not depend on valid, so this addi is not consumed
    instr_i = enc_i(12'h123, 5'd0, 3'd0, 5'd1);
    @(negedge CLK);
    check_word(32'(wb_valid_o), 32'd0, "wb_valid_o after reset");
    check_word(32'(illegal_o), 32'd0, "illegal_o after reset");
    check_word(32'(accept_o), 32'd1, "accept_o for addi after reset");
    @(posedge CLK);
    #1;
    for (i = 1; i < `NUM_REGS; i++) begin
      load_reg(5'(i), $urandom);
    end
    wait_drain();
  endtask

  task automatic alu_op_sweep();
    int round, f3;
    logic [4:0] shamt;
    for (round = 0; round < 6; round++) begin
      load_reg(rand_reg(1), $urandom);
      for (f3 = 0; f3 < 8; f3++) begin
        // x0 now and then as destination
        issue_instr(enc_r(7'h00, rand_reg(1), rand_reg(1), 3'(f3),
                          ($urandom % 8 == 0) ? 5'd0 : rand_reg(1)));
        if (f3 == 0 || f3 == 5) begin
          issue_instr(enc_r(7'h20, rand_reg(1), rand_reg(1), 3'(f3), rand_reg(0)));
        end
        shamt = 5'($urandom);
        case (f3)
          1: issue_instr(enc_i({7'h00, shamt}, rand_reg(1), 3'd1, rand_reg(0)));
          5: begin
            issue_instr(enc_i({7'h00, shamt}, rand_reg(1), 3'd5, rand_reg(0)));
            issue_instr(enc_i({7'h20, shamt}, rand_reg(1), 3'd5, rand_reg(0)));
          end
          default: issue_instr(enc_i(12'($urandom), rand_reg(1), 3'(f3), rand_reg(0)));
        endcase
      end
    end
    wait_drain();
  endtask

  // f3_base 0 selects the multiplies, 4 the divides
  task automatic muldiv_sweep(input int f3_base, input logic [31:0] edge_vals [5]);
    int i, j, k;
    for (i = 0; i < 5; i++) begin
      load_reg(5'(i + 1), edge_vals[i]);
    end
    for (i = 0; i < 5; i++) begin
      for (j = 0; j < 5; j++) begin
        for (k = 0; k < 4; k++) begin
          issue_instr(enc_r(7'h01, 5'(j + 1), 5'(i + 1), 3'(f3_base + k), rand_reg(6)));
        end
      end
    end
    for (i = 0; i < 20; i++) begin
      load_reg(5'd30, $urandom);
      load_reg(5'd31, $urandom);
      issue_instr(enc_r(7'h01, 5'd31, 5'd30, 3'(f3_base + $urandom % 4), rand_reg(6)));
    end
    wait_drain();
  endtask

  task automatic dependency_order();
    load_reg(5'd1, $urandom);
    load_reg(5'd2, $urandom | 32'h1);
    load_reg(5'd5, $urandom);
    load_reg(5'd7, $urandom);
    wait_drain();
    issue_instr(enc_r(7'h01, 5'd2, 5'd1, 3'd4, 5'd3));
    // independent work while the divider runs
    issue_instr(enc_i(12'h05a, 5'd7, 3'd0, 5'd6));
    issue_instr(enc_r(7'h00, 5'd7, 5'd6, 3'd0, 5'd8));
    // reads the quotient, must wait for it
    issue_instr(enc_r(7'h00, 5'd5, 5'd3, 3'd0, 5'd4));
    wait_drain();
    check_word(32'(write_order[6] < write_order[3]), 32'd1, "x6 written before quotient");
    check_word(32'(write_order[8] < write_order[3]), 32'd1, "x8 written before quotient");
    check_word(32'(write_order[3] < write_order[4]), 32'd1, "x4 written after quotient");
  endtask

  task automatic illegal_encodings();
    logic [31:0] bad [3];
    int i;
    bad[0] = {12'h004, 5'd1, 3'b010, 5'd9, 7'b0000011};
    bad[1] = enc_r(7'h02, 5'd2, 5'd1, 3'd0, 5'd9);
    bad[2] = enc_r(7'h20, 5'd2, 5'd1, 3'd6, 5'd9);
    for (i = 0; i < 3; i++) begin
      issue_instr(bad[i]);
      @(negedge CLK);
      check_word(32'(illegal_o), 32'd1, "illegal_o pulse");
      @(negedge CLK);
      check_word(32'(illegal_o), 32'd0, "illegal_o after pulse");
      @(posedge CLK);
      #1;
    end
    // copy x9 into x10, x9 must still hold its old value
    issue_instr(enc_r(7'h00, 5'd0, 5'd9, 3'd0, 5'd10));
    wait_drain();
  endtask

  initial begin
    int i;
    int e;
    int unsigned seed_val;
    logic [31:0] mul_edges [5];
    logic [31:0] div_edges [5];
    seed_val = $urandom(32'h5115_4ac2);
    CLK = 1'b0;
    reset_i = 1'b1;
    instr_i = '0;
    instr_valid_i = 1'b0;
    outstanding = 0;
    write_seq = 0;
    errors = 0;
    checks = 0;
    for (i = 0; i < `NUM_REGS; i++) begin
      ref_regs[i] = '0;
      exp_val[i] = '0;
      exp_pend[i] = 1'b0;
      write_order[i] = 0;
    end
    mul_edges = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
    div_edges = '{32'h0, 32'h1, 32'h7, 32'h8000_0000, 32'hffff_ffff};
    fork
      watch_writeback();
    join_none
    repeat (5) @(posedge CLK);
    #1;
    reset_i = 1'b0;
    e = errors;
    reset_and_load();
    report_test("reset_load", e);
    e = errors;
    alu_op_sweep();
    report_test("alu_ops", e);
    e = errors;
    muldiv_sweep(0, mul_edges);
    report_test("mul_ops", e);
    e = errors;
    muldiv_sweep(4, div_edges);
    report_test("div_ops", e);
    e = errors;
    dependency_order();
    report_test("dependencies", e);
    e = errors;
    illegal_encodings();
    report_test("illegal", e);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #2_000_000;
    $display("simulation time limit reached before the tests finished");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/rv32_exec_core.sv
// top of the rv32 decode, issue and execute slice
// control unit, three functional units, writeback arbiter and registers
`timescale 1ns/1ps
`default_nettype none

module rv32_exec_core (
  input  logic                     CLK,
  input  logic                     reset_i,
  input  rv32_exec_pkg::word_t     instr_i,
  input  logic                     instr_valid_i,
  output logic                     accept_o,
  output logic                     illegal_o,
  output logic                     wb_valid_o,
  output rv32_exec_pkg::reg_idx_t  wb_rd_o,
  output rv32_exec_pkg::word_t     wb_data_o
);
  import rv32_exec_pkg::*;

  reg_idx_t rs1, rs2;
  word_t rs1_data, rs2_data;

  fu_issue_if issue_bus ();
  wb_port_if  wb_arith ();
  wb_port_if  wb_mul ();
  wb_port_if  wb_div ();

  control_unit u_control (
    .CLK           (CLK),
    .reset_i       (reset_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .accept_o      (accept_o),
    .illegal_o     (illegal_o),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .wb_we_i       (wb_valid_o),
    .wb_rd_i       (wb_rd_o),
    .issue         (issue_bus.control)
  );

  reg_file u_reg_file (
    .CLK        (CLK),
    .reset_i    (reset_i),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rd_i       (wb_rd_o),
    .we_i       (wb_valid_o),
    .wdata_i    (wb_data_o),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  arith_unit u_arith (.CLK(CLK), .reset_i(reset_i), .issue(issue_bus.arith), .wb(wb_arith.unit));
  mul_unit u_mul (.CLK(CLK), .reset_i(reset_i), .issue(issue_bus.mul), .wb(wb_mul.unit));
  div_unit u_div (.CLK(CLK), .reset_i(reset_i), .issue(issue_bus.div), .wb(wb_div.unit));

  // the arbiter output is the write port and the top-level mirror
  wb_arbiter u_wb_arbiter (
    .CLK        (CLK),
    .reset_i    (reset_i),
    .port_div   (wb_div.arbiter),
    .port_mul   (wb_mul.arbiter),
    .port_arith (wb_arith.arbiter),
    .we_o       (wb_valid_o),
    .rd_o       (wb_rd_o),
    .wdata_o    (wb_data_o)
  );

endmodule

`default_nettype wire

//--- source/wb_arbiter.sv
// fixed-priority arbiter for the register file write port
// divider first, then multiplier, then the ALU
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
  input  logic                     CLK,
  input  logic                     reset_i,
  wb_port_if.arbiter               port_div,
  wb_port_if.arbiter               port_mul,
  wb_port_if.arbiter               port_arith,
  output logic                     we_o,
  output rv32_exec_pkg::reg_idx_t  rd_o,
  output rv32_exec_pkg::word_t     wdata_o
);
  import rv32_exec_pkg::*;

  assign port_div.grant   = port_div.req;
  assign port_mul.grant   = port_mul.req && !port_div.req;
  assign port_arith.grant = port_arith.req && !port_mul.req && !port_div.req;

  assign we_o = port_div.req || port_mul.req || port_arith.req;

  // steer the winner onto the write port
  always_comb begin
    if (port_div.req) begin
      rd_o    = port_div.rd;
      wdata_o = port_div.data;
    end else if (port_mul.req) begin
      rd_o    = port_mul.rd;
      wdata_o = port_mul.data;
    end else begin
      rd_o    = port_arith.rd;
      wdata_o = port_arith.data;
    end
  end

  a_grant_onehot: assert property (@(posedge CLK) disable iff (reset_i)
    $onehot0({port_div.grant, port_mul.grant, port_arith.grant}));

  a_grant_has_req: assert property (@(posedge CLK) disable iff (reset_i)
    (port_div.grant -> port_div.req) && (port_mul.grant -> port_mul.req) &&
    (port_arith.grant -> port_arith.req));

endmodule

`default_nettype wire

//--- source/div_unit.sv
// restoring divider for DIV, DIVU, REM and REMU
// works on magnitudes, one quotient bit per cycle, signs fixed at the end
`timescale 1ns/1ps
`default_nettype none

`include "rv32_exec_consts.svh"

module div_unit (
  input  logic    CLK,
  input  logic    reset_i,
  fu_issue_if.div issue,
  wb_port_if.unit wb
);
  import rv32_exec_pkg::*;

  div_state_t state;
  logic [$clog2(`DIV_STEPS)-1:0] step;
  word_t divisor, quo, rem;
  word_t quo_next, rem_next;
  logic [`XLEN:0] rem_shift, diff;
  logic fits, neg_quo, neg_rem, quot_sel;
  logic a_neg, b_neg;
  reg_idx_t rd_q;

  assign a_neg = (issue.sign == SIGNED) && issue.op_a[`XLEN-1];
  assign b_neg = (issue.sign == SIGNED) && issue.op_b[`XLEN-1];

  // trial subtract of the divisor from the shifted partial remainder
  assign rem_shift = {rem, quo[`XLEN-1]};
  assign diff      = rem_shift - {1'b0, divisor};
  assign fits      = !diff[`XLEN];
  assign rem_next  = fits ? diff[`XLEN-1:0] : rem_shift[`XLEN-1:0];
  assign quo_next  = {quo[`XLEN-2:0], fits};

  always_ff @(posedge CLK) begin
    if (reset_i) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (issue.ena_div) begin
            state <= RUN;
          end
        end
        RUN: begin
          if (step == $bits(step)'(`DIV_STEPS - 1)) begin
            state <= (rd_q != '0) ? DONE : IDLE;
          end
        end
        default: begin
          if (wb.grant) begin
            state <= IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == IDLE && issue.ena_div) begin
      quo      <= a_neg ? -issue.op_a : issue.op_a;
      divisor  <= b_neg ? -issue.op_b : issue.op_b;
      rem      <= '0;
      step     <= '0;
      // divide by zero keeps an all-ones quotient whatever the signs
      neg_quo  <= (a_neg ^ b_neg) && (issue.op_b != '0);
      neg_rem  <= a_neg;
      quot_sel <= issue.div_quot;
      rd_q     <= issue.rd;
    end else if (state == RUN) begin
      quo  <= quo_next;
      rem  <= rem_next;
      step <= step + 1'b1;
      if (quot_sel) begin
        wb.data <= neg_quo ? -quo_next : quo_next;
      end else begin
        wb.data <= neg_rem ? -rem_next : rem_next;
      end
    end
  end

  assign wb.req          = (state == DONE);
  assign wb.rd           = rd_q;
  assign issue.ready_div = (state == IDLE);

  a_div_idle_issue: assert property (@(posedge CLK) disable iff (reset_i)
    issue.ena_div |-> state == IDLE);

endmodule

`default_nettype wire

//--- source/mul_unit.sv
// two-stage multiplier for MUL, MULH, MULHSU and MULHU
// stage one extends the operands, stage two registers the product
`timescale 1ns/1ps
`default_nettype none

`include "rv32_exec_consts.svh"

module mul_unit (
  input  logic    CLK,
  input  logic    reset_i,
  fu_issue_if.mul issue,
  wb_port_if.unit wb
);
  import rv32_exec_pkg::*;

  logic signed [`XLEN:0] a_s1, b_s1;
  logic signed [2*`XLEN+1:0] product;
  reg_idx_t rd_s1;
  logic high_s1, valid_s1;

  // one extra bit makes every sign mode a signed multiply
  assign product = a_s1 * b_s1;

  always_ff @(posedge CLK) begin
    if (reset_i) begin
      valid_s1 <= 1'b0;
      wb.req   <= 1'b0;
    end else begin
      valid_s1 <= issue.ena_mul;
      if (valid_s1) begin
        wb.req <= (rd_s1 != '0);
      end else if (wb.grant) begin
        wb.req <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (issue.ena_mul) begin
      a_s1    <= {issue.sign != UNSIGNED && issue.op_a[`XLEN-1], issue.op_a};
      b_s1    <= {issue.sign == SIGNED && issue.op_b[`XLEN-1], issue.op_b};
      rd_s1   <= issue.rd;
      high_s1 <= issue.mul_high;
    end
    if (valid_s1) begin
      wb.data <= high_s1 ? product[2*`XLEN-1:`XLEN] : product[`XLEN-1:0];
      wb.rd   <= rd_s1;
    end
  end

  assign issue.ready_mul = !valid_s1 && !wb.req;

  // a new operation only arrives while nothing is held
  a_mul_issue_idle: assert property (@(posedge CLK) disable iff (reset_i)
    issue.ena_mul |-> issue.ready_mul);

endmodule

`default_nettype wire

//--- source/arith_unit.sv
// single-cycle ALU for register, immediate and LUI operations
// result is held on the writeback port until granted
`timescale 1ns/1ps
`default_nettype none

module arith_unit (
  input  logic      CLK,
  input  logic      reset_i,
  fu_issue_if.arith issue,
  wb_port_if.unit   wb
);
  import rv32_exec_pkg::*;

  word_t result;
  logic [4:0] shamt;

  assign shamt = issue.op_b[4:0];

  always_comb begin
    case (issue.alu_op)
      SUB: result = issue.op_a - issue.op_b;
      SLL: result = issue.op_a << shamt;
      SRL: result = issue.op_a >> shamt;
      SRA: result = word_t'($signed(issue.op_a) >>> shamt);
      AND: result = issue.op_a & issue.op_b;
      OR: result = issue.op_a | issue.op_b;
      XOR: result = issue.op_a ^ issue.op_b;
      SLT: result = word_t'($signed(issue.op_a) < $signed(issue.op_b));
      SLTU: result = word_t'(issue.op_a < issue.op_b);
      PASS_B: result = issue.op_b;
      default: result = issue.op_a + issue.op_b;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset_i) begin
      wb.req <= 1'b0;
    end else if (issue.ena_arith) begin
      wb.req <= (issue.rd != '0);
    end else if (wb.grant) begin
      wb.req <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (issue.ena_arith) begin
      wb.data <= result;
      wb.rd   <= issue.rd;
    end
  end

  assign issue.ready_arith = !wb.req;

endmodule

`default_nettype wire

//--- source/reg_file.sv
// integer register file, two async read ports and one write port
`timescale 1ns/1ps
`default_nettype none

`include "rv32_exec_consts.svh"

module reg_file (
  input  logic                     CLK,
  input  logic                     reset_i,
  input  rv32_exec_pkg::reg_idx_t  rs1_i,
  input  rv32_exec_pkg::reg_idx_t  rs2_i,
  input  rv32_exec_pkg::reg_idx_t  rd_i,
  input  logic                     we_i,
  input  rv32_exec_pkg::word_t     wdata_i,
  output rv32_exec_pkg::word_t     rs1_data_o,
  output rv32_exec_pkg::word_t     rs2_data_o
);
  import rv32_exec_pkg::*;

  word_t regs [`NUM_REGS];

  // x0 is cleared on reset and never written
  always_ff @(posedge CLK) begin
    if (reset_i) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_i != '0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rs1_data_o = regs[rs1_i];
  assign rs2_data_o = regs[rs2_i];

endmodule

`default_nettype wire

//--- source/control_unit.sv
// instruction decode, illegal detection and scoreboarded issue
// registers the chosen operation onto the issue bus on accept
`timescale 1ns/1ps
`default_nettype none

`include "rv32_exec_consts.svh"

module control_unit (
  input  logic                     CLK,
  input  logic                     reset_i,
  input  rv32_exec_pkg::word_t     instr_i,
  input  logic                     instr_valid_i,
  output logic                     accept_o,
  output logic                     illegal_o,
  output rv32_exec_pkg::reg_idx_t  rs1_o,
  output rv32_exec_pkg::reg_idx_t  rs2_o,
  input  rv32_exec_pkg::word_t     rs1_data_i,
  input  rv32_exec_pkg::word_t     rs2_data_i,
  input  logic                     wb_we_i,
  input  rv32_exec_pkg::reg_idx_t  wb_rd_i,
  fu_issue_if.control              issue
);
  import rv32_exec_pkg::*;

  opcode_t opcode;
  reg_idx_t rd;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic illegal;
  fu_sel_t fu_sel;
  alu_op_t alu_op;
  sign_t sign;
  word_t op_b;
  logic uses_rs1, uses_rs2;
  logic unit_free, hazard, fire;
  logic [`NUM_REGS-1:0] pending, clr_mask, set_mask;

  assign opcode = opcode_t'(instr_i[6:0]);
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];

  // only REGREG carries a funct7 worth checking
  always_comb begin
    case (opcode)
      REGREG: begin
        case (funct7)
          7'b000_0000, 7'b000_0001: illegal = 1'b0;
          7'b010_0000: illegal = !(funct3 == 3'b000 || funct3 == 3'b101);
          default: illegal = 1'b1;
        endcase
      end
      IMMED, LUI: illegal = 1'b0;
      default: illegal = 1'b1;
    endcase
  end

  // M extension lives under funct7 = 1, funct3[2] splits mul from div
  assign fu_sel = (opcode == REGREG && funct7 == 7'b000_0001) ?
                  (funct3[2] ? DIV_S : MUL_S) : ARITH_S;

  always_comb begin
    case (funct3)
      3'b000: alu_op = (opcode == REGREG && instr_i[30]) ? SUB : ADD;
      3'b001: alu_op = SLL;
      3'b010: alu_op = SLT;
      3'b011: alu_op = SLTU;
      3'b100: alu_op = XOR;
      3'b101: alu_op = instr_i[30] ? SRA : SRL;
      3'b110: alu_op = OR;
      default: alu_op = AND;
    endcase
    if (opcode == LUI) begin
      alu_op = PASS_B;
    end
  end

  always_comb begin
    case (funct3)
      3'b011, 3'b101, 3'b111: sign = UNSIGNED;
      3'b010: sign = SIGNED_UNSIGNED;
      default: sign = SIGNED;
    endcase
  end

  // operand b is rs2, the I-type immediate or the U-type immediate
  always_comb begin
    case (opcode)
      REGREG: op_b = rs2_data_i;
      LUI: op_b = {instr_i[31:12], 12'b0};
      default: op_b = {{20{instr_i[31]}}, instr_i[31:20]};
    endcase
  end

  // a unit is busy one cycle early, while its enable is in flight
  always_comb begin
    case (fu_sel)
      MUL_S: unit_free = issue.ready_mul && !issue.ena_mul;
      DIV_S: unit_free = issue.ready_div && !issue.ena_div;
      default: unit_free = issue.ready_arith && !issue.ena_arith;
    endcase
  end

  assign uses_rs1 = (opcode != LUI);
  assign uses_rs2 = (opcode == REGREG);
  assign hazard = (uses_rs1 && pending[rs1_o]) || (uses_rs2 && pending[rs2_o]) ||
                  pending[rd];

  assign accept_o = illegal || (unit_free && !hazard);
  assign fire = instr_valid_i && accept_o;

  // x0 is never marked, nothing would ever clear it
  assign clr_mask = wb_we_i ? (`NUM_REGS'(1) << wb_rd_i) : '0;
  assign set_mask = (fire && !illegal && rd != '0) ? (`NUM_REGS'(1) << rd) : '0;

  always_ff @(posedge CLK) begin
    if (reset_i) begin
      pending         <= '0;
      illegal_o       <= 1'b0;
      issue.ena_arith <= 1'b0;
      issue.ena_mul   <= 1'b0;
      issue.ena_div   <= 1'b0;
    end else begin
      pending         <= (pending & ~clr_mask) | set_mask;
      illegal_o       <= fire && illegal;
      issue.ena_arith <= fire && !illegal && fu_sel == ARITH_S;
      issue.ena_mul   <= fire && !illegal && fu_sel == MUL_S;
      issue.ena_div   <= fire && !illegal && fu_sel == DIV_S;
    end
  end

  always_ff @(posedge CLK) begin
    if (fire) begin
      issue.op_a     <= rs1_data_i;
      issue.op_b     <= op_b;
      issue.rd       <= rd;
      issue.alu_op   <= alu_op;
      issue.sign     <= sign;
      issue.mul_high <= |funct3[1:0];
      issue.div_quot <= !funct3[1];
    end
  end

endmodule

`default_nettype wire

//--- source/wb_port_if.sv
// one unit's writeback request toward the shared register write port
`timescale 1ns/1ps
`default_nettype none

interface wb_port_if;
  import rv32_exec_pkg::*;

  logic req;
  reg_idx_t rd;
  word_t data;
  logic grant;

  modport unit (output req, rd, data, input grant);
  modport arbiter (input req, rd, data, output grant);
endinterface

`default_nettype wire

//--- source/fu_issue_if.sv
// issue bus from the control unit to the three functional units
// enables are one-cycle strobes, readies flow back to the control unit
`timescale 1ns/1ps
`default_nettype none

interface fu_issue_if;
  import rv32_exec_pkg::*;

  logic ena_arith, ena_mul, ena_div;
  word_t op_a;
  word_t op_b;
  reg_idx_t rd;
  alu_op_t alu_op;
  sign_t sign;
  logic mul_high, div_quot;
  logic ready_arith, ready_mul, ready_div;

  modport control (
    output ena_arith, ena_mul, ena_div, op_a, op_b, rd, alu_op, sign, mul_high, div_quot,
    input  ready_arith, ready_mul, ready_div
  );
  modport arith (input ena_arith, op_a, op_b, rd, alu_op, output ready_arith);
  modport mul (input ena_mul, op_a, op_b, rd, sign, mul_high, output ready_mul);
  modport div (input ena_div, op_a, op_b, rd, sign, div_quot, output ready_div);
endinterface

`default_nettype wire

//--- source/rv32_exec_pkg.sv
// types shared by the decode, issue and execute slice
// register indices, words, opcodes, ALU ops and unit selection
`default_nettype none

`include "rv32_exec_consts.svh"

package rv32_exec_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

  // major opcodes, only REGREG, IMMED and LUI are executed here
  typedef enum logic [6:0] {
    REGREG  = 7'b0110011,
    IMMED   = 7'b0010011,
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    BRANCH  = 7'b1100011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    MISCMEM = 7'b0001111,
    SYSTEM  = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SRL, SRA, AND, OR, XOR, SLT, SLTU, PASS_B
  } alu_op_t;

  typedef enum logic [1:0] {ARITH_S, MUL_S, DIV_S} fu_sel_t;

  typedef enum logic [1:0] {SIGNED, UNSIGNED, SIGNED_UNSIGNED} sign_t;

  typedef enum logic [1:0] {IDLE, RUN, DONE} div_state_t;

endpackage

`default_nettype wire

//--- include/rv32_exec_consts.svh
// widths and latencies for the rv32 execute slice
// fixed by the ISA, shared by the package, the units and the testbench
`ifndef RV32_EXEC_CONSTS_SVH
`define RV32_EXEC_CONSTS_SVH

// data word width
`define XLEN 32

// architectural registers, x0 included
`define NUM_REGS 32

// restoring divider produces one quotient bit per step
`define DIV_STEPS 32

// register stages in the multiplier
`define MUL_STAGES 2

`endif
